// File: hw/mems_pkg.sv
`default_nettype none

package mems_pkg;

  // One SPI transaction to the MEMS part
  localparam int FRAME_BITS  = 24;
  localparam int FRAME_BYTES = 3;   // UART bytes per frame, MSB first

  typedef logic [7:0]            byte_t;   // One UART character
  typedef logic [FRAME_BITS-1:0] frame_t;  // Command or readback word

  // Command parser sequence
  typedef enum logic [2:0] {
    COLLECT,    // Gathering host bytes
    LAUNCH,     // One-cycle start to the SPI master
    WAIT_SPI,
    SEND_BYTE,  // Offer next reply byte to the transmitter
    WAIT_TX
  } parser_state_t;

  // SPI master; prefixed since IDLE is also a UART state
  typedef enum logic [1:0] {SPI_IDLE, SPI_SELECT, SPI_SHIFT, SPI_RELEASE} spi_state_t;

  // Shared by receiver and transmitter
  typedef enum logic [1:0] {UART_IDLE, UART_START, UART_DATA, UART_STOP} uart_state_t;

endpackage

`default_nettype wire

// File: hw/spi_xfer_if.sv
`timescale 1ns/1ns
`default_nettype none

interface spi_xfer_if;
  import mems_pkg::*;

  logic   start;     // One-cycle request strobe
  logic   busy;      // Transfer in flight
  logic   done;      // One-cycle completion strobe
  frame_t tx_frame;  // Valid with start
  frame_t rx_frame;  // Valid with done, held until next start

  // Command parser side
  modport requester (output start, output tx_frame, input busy, input done, input rx_frame);

  // SPI master side
  modport responder (input start, input tx_frame, output busy, output done, output rx_frame);

endinterface

`default_nettype wire

// File: hw/uart_rx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_rx #(
  parameter int CLKS_PER_BIT = 16
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            rxd,
  output mems_pkg::byte_t rx_byte,
  output logic            rx_valid
);
  import mems_pkg::*;

  localparam int                CNT_W     = $clog2(CLKS_PER_BIT + 1);
  localparam logic [CNT_W-1:0]  BIT_LAST  = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0]  HALF_LAST = CNT_W'(CLKS_PER_BIT / 2 - 1);

  uart_state_t      state;
  logic             rxd_meta;
  logic             rxd_sync;   // Safe to use from here on
  logic [CNT_W-1:0] clk_cnt;    // Cycles within the current bit
  logic [2:0]       bit_cnt;    // Data bit index
  logic             bit_tick;   // Middle of a data or stop bit
  byte_t            shreg;

  assign bit_tick = (clk_cnt == BIT_LAST);

  // Two-flop synchronizer, idles high like the line
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
    end else begin
      rxd_meta <= rxd;
      rxd_sync <= rxd_meta;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= UART_IDLE;
      clk_cnt  <= '0;
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;  // Strobe by default
      case (state)
        UART_IDLE: begin
          clk_cnt <= '0;
          bit_cnt <= '0;
          if (!rxd_sync) state <= UART_START;  // Falling edge of start bit
        end
        UART_START: begin
          if (clk_cnt == HALF_LAST) begin
            clk_cnt <= '0;
            // Glitch check at mid start bit
            state   <= rxd_sync ? UART_IDLE : UART_DATA;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        UART_DATA: begin
          if (bit_tick) begin
            clk_cnt <= '0;
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) state <= UART_STOP;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        UART_STOP: begin
          if (bit_tick) begin
            clk_cnt  <= '0;
            rx_valid <= rxd_sync;  // Framing error drops the byte
            state    <= UART_IDLE;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        default: state <= UART_IDLE;
      endcase
    end
  end

  // Data path, LSB arrives first
  always_ff @(posedge clk) begin
    if (state == UART_DATA && bit_tick) shreg <= {rxd_sync, shreg[7:1]};
    if (state == UART_STOP && bit_tick) rx_byte <= shreg;
  end

endmodule

`default_nettype wire

// File: hw/uart_tx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_tx #(
  parameter int CLKS_PER_BIT = 16
) (
  input  logic            clk,
  input  logic            rst_n,
  input  mems_pkg::byte_t tx_byte,
  input  logic            tx_start,
  input  logic            tx_block,  // Host not ready
  output logic            txd,
  output logic            tx_busy
);
  import mems_pkg::*;

  localparam int               CNT_W    = $clog2(CLKS_PER_BIT + 1);
  localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);

  uart_state_t      state;
  logic [CNT_W-1:0] clk_cnt;
  logic [2:0]       bit_cnt;
  logic             bit_tick;  // Last cycle of a bit
  logic             pending;   // Byte latched, held off by tx_block
  logic             launch;
  byte_t            shreg;

  assign bit_tick = (clk_cnt == BIT_LAST);
  assign launch   = (tx_start || pending) && !tx_block;
  assign tx_busy  = (state != UART_IDLE) || pending;  // Back-pressure to the parser

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= UART_IDLE;
      clk_cnt <= '0;
      bit_cnt <= '0;
      pending <= 1'b0;
      txd     <= 1'b1;  // Line idles high
    end else begin
      case (state)
        UART_IDLE: begin
          clk_cnt <= '0;
          bit_cnt <= '0;
          if (launch) begin
            pending <= 1'b0;
            txd     <= 1'b0;  // Start bit
            state   <= UART_START;
          end else if (tx_start) begin
            pending <= 1'b1;
          end
        end
        UART_START: begin
          clk_cnt <= bit_tick ? '0 : clk_cnt + 1'b1;
          if (bit_tick) begin
            txd   <= shreg[0];
            state <= UART_DATA;
          end
        end
        UART_DATA: begin
          clk_cnt <= bit_tick ? '0 : clk_cnt + 1'b1;
          if (bit_tick) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) begin
              txd   <= 1'b1;  // Stop bit
              state <= UART_STOP;
            end else begin
              txd <= shreg[1];  // Next bit before the shift lands
            end
          end
        end
        UART_STOP: begin
          clk_cnt <= bit_tick ? '0 : clk_cnt + 1'b1;
          if (bit_tick) state <= UART_IDLE;
        end
        default: state <= UART_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == UART_IDLE && tx_start) shreg <= tx_byte;
    else if (state == UART_DATA && bit_tick) shreg <= {1'b0, shreg[7:1]};
  end

endmodule

`default_nettype wire

// File: hw/cmd_parser.sv
`timescale 1ns/1ns
`default_nettype none

module cmd_parser #(
  parameter int BYTE_TIMEOUT = 4096
) (
  input  logic            clk,
  input  logic            rst_n,
  input  mems_pkg::byte_t rx_byte,
  input  logic            rx_valid,
  output mems_pkg::byte_t tx_byte,
  output logic            tx_start,
  input  logic            tx_busy,
  spi_xfer_if.requester   spi
);
  import mems_pkg::*;

  localparam int                IDLE_W    = $clog2(BYTE_TIMEOUT + 1);
  localparam logic [IDLE_W-1:0] IDLE_LAST = IDLE_W'(BYTE_TIMEOUT - 1);
  localparam int                BCNT_W    = $clog2(FRAME_BYTES + 1);
  localparam logic [BCNT_W-1:0] BYTE_LAST = BCNT_W'(FRAME_BYTES - 1);
  localparam int                BYTE_BITS = $bits(byte_t);

  parser_state_t     state;
  frame_t            cmd_frame;  // Host command, MSB byte first
  frame_t            reply;      // Readback, shifted out byte by byte
  logic [BCNT_W-1:0] byte_cnt;   // Bytes collected, then bytes sent
  logic [IDLE_W-1:0] idle_cnt;   // Gap since last byte of a partial frame
  logic              timeout;

  assign timeout = (byte_cnt != '0) && (idle_cnt == IDLE_LAST);

  // Start is high for the single LAUNCH cycle
  assign spi.start    = (state == LAUNCH);
  assign spi.tx_frame = cmd_frame;

  // Handshake to the transmitter, only when it is free
  assign tx_start = (state == SEND_BYTE) && !tx_busy;
  assign tx_byte  = reply[FRAME_BITS-1 -: BYTE_BITS];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= COLLECT;
      byte_cnt <= '0;
      idle_cnt <= '0;
    end else begin
      case (state)
        COLLECT: begin
          if (rx_valid) begin
            idle_cnt <= '0;
            if (byte_cnt == BYTE_LAST) begin
              byte_cnt <= '0;
              state    <= LAUNCH;
            end else begin
              byte_cnt <= byte_cnt + 1'b1;
            end
          end else if (timeout) begin
            byte_cnt <= '0;  // Drop the partial frame
            idle_cnt <= '0;
          end else if (byte_cnt != '0) begin
            idle_cnt <= idle_cnt + 1'b1;
          end
        end
        LAUNCH: state <= WAIT_SPI;
        WAIT_SPI: begin
          if (spi.done) state <= SEND_BYTE;  // byte_cnt already zero
        end
        SEND_BYTE: begin
          if (!tx_busy) state <= WAIT_TX;
        end
        WAIT_TX: begin
          // tx_busy is up the cycle after tx_start, so this waits out the byte
          if (!tx_busy) begin
            if (byte_cnt == BYTE_LAST) begin
              byte_cnt <= '0;
              state    <= COLLECT;
            end else begin
              byte_cnt <= byte_cnt + 1'b1;
              state    <= SEND_BYTE;
            end
          end
        end
        default: state <= COLLECT;
      endcase
    end
  end

  // Frame assembly and reply serialization
  always_ff @(posedge clk) begin
    if (state == COLLECT && rx_valid) begin
      cmd_frame <= {cmd_frame[FRAME_BITS-BYTE_BITS-1:0], rx_byte};
    end
    if (state == WAIT_SPI && spi.done) begin
      reply <= spi.rx_frame;
    end else if (tx_start) begin
      reply <= reply << BYTE_BITS;  // Next byte to the top
    end
  end

endmodule

`default_nettype wire

// File: hw/mems_spi_master.sv
`timescale 1ns/1ns
`default_nettype none

module mems_spi_master #(
  parameter int SPI_CLK_DIV = 4  // Cycles per sck half period
) (
  input  logic          clk,
  input  logic          rst_n,
  spi_xfer_if.responder spi,
  input  logic          miso,
  output logic          mosi,
  output logic          sck,
  output logic          cs_n
);
  import mems_pkg::*;

  localparam int               DIV_W    = $clog2(SPI_CLK_DIV + 1);
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(SPI_CLK_DIV - 1);
  localparam int               BIT_W    = $clog2(FRAME_BITS + 1);
  localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(FRAME_BITS - 1);

  spi_state_t       state;
  logic [DIV_W-1:0] div_cnt;
  logic [BIT_W-1:0] bit_cnt;    // Falling edges so far
  logic             half_tick;  // End of a half period
  logic             done_q;
  frame_t           tx_shreg;   // MSB drives mosi
  frame_t           rx_shreg;

  assign half_tick    = (div_cnt == DIV_LAST);
  assign spi.busy     = (state != SPI_IDLE);
  assign spi.done     = done_q;
  assign spi.rx_frame = rx_shreg;  // Untouched until the next transfer samples
  assign mosi         = tx_shreg[FRAME_BITS-1];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= SPI_IDLE;
      div_cnt <= '0;
      bit_cnt <= '0;
      sck     <= 1'b0;  // Mode 0 idle
      cs_n    <= 1'b1;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (state == SPI_IDLE || half_tick) div_cnt <= '0;
      else div_cnt <= div_cnt + 1'b1;
      case (state)
        SPI_IDLE: begin
          bit_cnt <= '0;
          if (spi.start) begin
            cs_n  <= 1'b0;
            state <= SPI_SELECT;
          end
        end
        SPI_SELECT: begin
          // Setup time, first bit already on mosi
          if (half_tick) begin
            sck   <= 1'b1;
            state <= SPI_SHIFT;
          end
        end
        SPI_SHIFT: begin
          if (half_tick) begin
            sck <= ~sck;
            if (sck) begin  // Falling edge
              if (bit_cnt == BIT_LAST) state <= SPI_RELEASE;
              else bit_cnt <= bit_cnt + 1'b1;
            end
          end
        end
        SPI_RELEASE: begin
          // Hold time after last fall
          if (half_tick) begin
            cs_n   <= 1'b1;
            done_q <= 1'b1;
            state  <= SPI_IDLE;
          end
        end
        default: state <= SPI_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == SPI_IDLE && spi.start) begin
      tx_shreg <= spi.tx_frame;
    end else if (state == SPI_SHIFT && half_tick && sck) begin
      tx_shreg <= tx_shreg << 1;  // mosi moves on the fall
    end
    // Sample on every rising edge
    if (half_tick && (state == SPI_SELECT || (state == SPI_SHIFT && !sck))) begin
      rx_shreg <= {rx_shreg[FRAME_BITS-2:0], miso};
    end
  end

endmodule

`default_nettype wire

// File: hw/frame_clk_gen.sv
`timescale 1ns/1ns
`default_nettype none

module frame_clk_gen #(
  parameter int FCLK_DIV = 50  // Cycles per half period
) (
  input  logic clk,
  input  logic rst_n,
  output logic fclk
);

  localparam int               CNT_W    = $clog2(FCLK_DIV + 1);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(FCLK_DIV - 1);

  logic [CNT_W-1:0] div_cnt;

  // Toggle flop gives 50% duty
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      div_cnt <= '0;
      fclk    <= 1'b0;  // Starts low
    end else if (div_cnt == CNT_LAST) begin
      div_cnt <= '0;
      fclk    <= ~fclk;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: hw/mems_bridge_top.sv
`timescale 1ns/1ns
`default_nettype none

module mems_bridge_top #(
  parameter int CLKS_PER_BIT = 16,
  parameter int SPI_CLK_DIV  = 4,
  parameter int FCLK_DIV     = 50,
  parameter int BYTE_TIMEOUT = 4096
) (
  input  logic clk,
  input  logic rst_n,
  input  logic uart_rxd,   // From host
  input  logic tx_block,   // Host receive buffer full
  output logic uart_txd,   // To host
  input  logic spi_miso,
  output logic spi_mosi,
  output logic spi_sck,
  output logic spi_cs_n,
  output logic fclk,       // Sensor frame clock
  output logic sensor_en
);
  import mems_pkg::*;

  byte_t rx_byte;
  logic  rx_valid;
  byte_t tx_byte;
  logic  tx_start;
  logic  tx_busy;

  spi_xfer_if spi_xfer ();

  assign sensor_en = 1'b1;  // Sensor always powered

  uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_rx_inst (
    .clk(clk), .rst_n(rst_n), .rxd(uart_rxd), .rx_byte(rx_byte), .rx_valid(rx_valid)
  );

  cmd_parser #(.BYTE_TIMEOUT(BYTE_TIMEOUT)) cmd_parser_inst (
    .clk(clk), .rst_n(rst_n), .rx_byte(rx_byte), .rx_valid(rx_valid),
    .tx_byte(tx_byte), .tx_start(tx_start), .tx_busy(tx_busy), .spi(spi_xfer.requester)
  );

  uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_tx_inst (
    .clk(clk), .rst_n(rst_n), .tx_byte(tx_byte), .tx_start(tx_start),
    .tx_block(tx_block), .txd(uart_txd), .tx_busy(tx_busy)
  );

  mems_spi_master #(.SPI_CLK_DIV(SPI_CLK_DIV)) mems_spi_master_inst (
    .clk(clk), .rst_n(rst_n), .spi(spi_xfer.responder),
    .miso(spi_miso), .mosi(spi_mosi), .sck(spi_sck), .cs_n(spi_cs_n)
  );

  frame_clk_gen #(.FCLK_DIV(FCLK_DIV)) frame_clk_gen_inst (
    .clk(clk), .rst_n(rst_n), .fclk(fclk)
  );

endmodule

`default_nettype wire

// File: sim/mems_bridge_sva.sv
`timescale 1ns/1ns
`default_nettype none

module mems_bridge_sva (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  spi_cs_n,
  input logic                  spi_sck,
  input logic                  start,     // Parser request strobe
  input logic                  busy,      // SPI master in a transfer
  input logic                  uart_txd,
  input logic                  tx_block,
  input mems_pkg::uart_state_t tx_state   // Transmitter FSM
);
  import mems_pkg::*;

  // Synchronous reset, so check one edge later
  reset_idle: assert property (@(posedge clk) !rst_n |=> spi_cs_n && !spi_sck)
    else $error("SPI bus not idle after a reset cycle");

  sck_quiet: assert property (@(posedge clk) disable iff (!rst_n) spi_cs_n |-> !spi_sck)
    else $error("sck active while chip select is high");

  start_when_free: assert property (@(posedge clk) disable iff (!rst_n) busy |-> !start)
    else $error("SPI start raised while the master is busy");

  // Idle line stays high while the host holds off
  txd_held: assert property (@(posedge clk) disable iff (!rst_n)
      (tx_block && tx_state == UART_IDLE && uart_txd) |=> uart_txd)
    else $error("Start bit sent while tx_block is high");

endmodule

bind mems_bridge_top mems_bridge_sva mems_bridge_sva_inst (
  .clk(clk), .rst_n(rst_n), .spi_cs_n(spi_cs_n), .spi_sck(spi_sck),
  .start(spi_xfer.start), .busy(spi_xfer.busy),
  .uart_txd(uart_txd), .tx_block(tx_block), .tx_state(uart_tx_inst.state)
);

`default_nettype wire

// File: sim/mems_bridge_tb.sv
`timescale 1ns/1ns
`default_nettype none

module mems_bridge_tb;
  import mems_pkg::*;

  localparam int    CLK_PERIOD    = 8;
  localparam int    CLKS_PER_BIT  = 16;
  localparam int    SPI_CLK_DIV   = 4;
  localparam int    FCLK_DIV      = 50;
  localparam int    BYTE_TIMEOUT  = 1024;  // Short idle limit keeps the timeout test brief
  localparam int    BYTE_CYCLES   = 10 * CLKS_PER_BIT;  // Start, 8 data, stop
  localparam int    WAIT_LIMIT    = 2 * FRAME_BYTES * BYTE_CYCLES + 4 * FRAME_BITS * SPI_CLK_DIV;
  localparam int    MARGIN_CYCLES = 4 * BYTE_TIMEOUT + 20000;
  localparam string STIM_FILE     = "sim/mems_stim.txt";

  logic clk;
  logic rst_n;
  logic uart_rxd, tx_block, uart_txd;     // Host side
  logic spi_miso, spi_mosi, spi_sck, spi_cs_n;  // Sensor side
  logic fclk, sensor_en;

  frame_t stim_frame[$];       // Command words from the stim file
  frame_t stim_resp[$];        // Slave words, also the expected reply
  byte_t  reply_q[$];          // Bytes decoded from uart_txd
  frame_t slave_resp;          // Word returned in the next transfer
  frame_t captured;            // Last word seen on mosi
  int     xfer_count     = 0;
  int     blocked_starts = 0;  // Start bits seen while tx_block high
  int     errors         = 0;
  int     test_err_base  = 0;
  int     tests_passed   = 0;
  int     tests_failed   = 0;
  bit     stim_ready     = 1'b0;

  mems_bridge_top #(
    .CLKS_PER_BIT(CLKS_PER_BIT), .SPI_CLK_DIV(SPI_CLK_DIV),
    .FCLK_DIV(FCLK_DIV), .BYTE_TIMEOUT(BYTE_TIMEOUT)
  ) mems_bridge_top_inst (
    .clk(clk), .rst_n(rst_n), .uart_rxd(uart_rxd), .tx_block(tx_block), .uart_txd(uart_txd),
    .spi_miso(spi_miso), .spi_mosi(spi_mosi), .spi_sck(spi_sck), .spi_cs_n(spi_cs_n),
    .fclk(fclk), .sensor_en(sensor_en)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // One UART bit, changed 1 ns after the edge
  task automatic drive_bit(input logic value);
    @(posedge clk);
    #1 uart_rxd = value;
    repeat (CLKS_PER_BIT - 1) @(posedge clk);
  endtask

  task automatic send_byte(input byte_t data);
    drive_bit(1'b0);
    for (int i = 0; i < 8; i++) drive_bit(data[i]);  // LSB first
    drive_bit(1'b1);
  endtask

  task automatic send_frame(input frame_t frame);
    for (int i = FRAME_BYTES - 1; i >= 0; i--) send_byte(frame[i*8 +: 8]);  // MSB byte first
  endtask

  task automatic check_frame(input string name, input frame_t expected, input frame_t actual);
    if (actual !== expected) begin
      $display("Error %s: expected %h, actual %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic check_byte(input string name, input byte_t expected, input byte_t actual);
    if (actual !== expected) begin
      $display("Error %s: expected %h, actual %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input int expected, input int actual);
    if (actual != expected) begin
      $display("Error %s: expected %0d, actual %0d", name, expected, actual);
      errors++;
    end
  endtask

  task automatic start_test();
    test_err_base = errors;
  endtask

  task automatic end_test(input string name);
    if (errors == test_err_base) begin
      tests_passed++;
      $display("%s: pass", name);
    end else begin
      tests_failed++;
      $display("%s: FAIL", name);
    end
  endtask

  task automatic wait_xfer(input string name, input int target);
    int cycles;
    cycles = 0;
    while (xfer_count < target && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (xfer_count < target) begin
      $display("%s: no SPI transfer finished within %0d cycles", name, WAIT_LIMIT);
      errors++;
    end
  endtask

  task automatic wait_replies(input string name, input int count);
    int cycles;
    cycles = 0;
    while (reply_q.size() < count && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (reply_q.size() < count) begin
      $display("%s: only %0d reply bytes arrived", name, reply_q.size());
      errors++;
    end
  endtask

  task automatic check_readback(input string name, input frame_t resp);
    for (int i = FRAME_BYTES - 1; i >= 0; i--) begin
      if (reply_q.size() > 0) check_byte(name, resp[i*8 +: 8], reply_q.pop_front());
    end
  endtask

  // Full exchange: command out, SPI word checked, reply checked
  task automatic run_frame(input string name, input frame_t frame, input frame_t resp);
    int target;
    target     = xfer_count + 1;
    slave_resp = resp;
    reply_q.delete();
    send_frame(frame);
    wait_xfer(name, target);
    check_frame(name, frame, captured);
    wait_replies(name, FRAME_BYTES);
    check_readback(name, resp);
  endtask

  // SPI slave, mode 0
  initial begin
    frame_t shift;
    frame_t cap;
    forever begin
      @(negedge spi_cs_n);
      #1;
      shift    = slave_resp;
      spi_miso = shift[FRAME_BITS-1];  // First bit ready before first rise
      for (int i = 0; i < FRAME_BITS; i++) begin
        @(posedge spi_sck);
        cap = {cap[FRAME_BITS-2:0], spi_mosi};
        @(negedge spi_sck);
        #1;
        shift    = shift << 1;
        spi_miso = shift[FRAME_BITS-1];
      end
      @(posedge spi_cs_n);
      captured = cap;
      xfer_count++;
    end
  end

  // Host-side receiver, samples on the falling clock edge
  initial begin
    byte_t data;
    forever begin
      @(negedge uart_txd);
      if (tx_block) blocked_starts++;
      repeat (CLKS_PER_BIT / 2) @(negedge clk);  // Middle of start bit
      if (!uart_txd) begin
        for (int i = 0; i < 8; i++) begin
          repeat (CLKS_PER_BIT) @(negedge clk);
          data[i] = uart_txd;
        end
        repeat (CLKS_PER_BIT) @(negedge clk);
        if (uart_txd) begin
          reply_q.push_back(data);
        end else begin
          $display("Reply byte from the DUT had no stop bit");
          errors++;
        end
      end
    end
  end

  // Watchdog sized from the number of stim lines
  initial begin
    longint limit;
    wait (stim_ready);
    limit = longint'(stim_frame.size()) * (2 * FRAME_BYTES) * BYTE_CYCLES * 2 + MARGIN_CYCLES;
    repeat (limit) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the tests did not complete", limit);
    $display("Finished with errors");
    $finish;
  end

  initial begin
    frame_t frame;
    frame_t resp;
    int     fd;
    int     n_read;
    int     last;
    int     target;
    longint t_rise;
    rst_n    = 1'b0;
    uart_rxd = 1'b1;  // Line idle
    tx_block = 1'b0;
    spi_miso = 1'b0;
    void'($urandom(32'h4366));
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("Cannot open stimulus file %s", STIM_FILE);
      errors++;
    end else begin
      while (!$feof(fd)) begin
        n_read = $fscanf(fd, "%h %h\n", frame, resp);
        if (n_read != 2) break;
        stim_frame.push_back(frame);
        stim_resp.push_back(resp);
      end
      $fclose(fd);
      if (stim_frame.size() == 0) begin
        $display("No stimulus lines found in %s", STIM_FILE);
        errors++;
      end
    end
    stim_ready = 1'b1;
    repeat (5) @(posedge clk);
    #1 rst_n = 1'b1;

    start_test();
    @(posedge fclk);
    t_rise = $time;
    @(posedge fclk);
    check_count("fclk_period", 2 * FCLK_DIV, int'(($time - t_rise) / CLK_PERIOD));
    @(negedge clk);
    check_count("sensor_en", 1, int'(sensor_en));
    end_test("frame_clock");

    if (stim_frame.size() > 0) begin
      for (int i = 0; i < stim_frame.size(); i++) begin
        start_test();
        run_frame($sformatf("frame_%0d", i), stim_frame[i], stim_resp[i]);
        end_test($sformatf("frame_%0d", i));
        repeat (20) @(posedge clk);
      end

      // Stray byte must age out before the real frame
      start_test();
      send_byte(8'hA5);
      repeat (BYTE_TIMEOUT + 100) @(posedge clk);
      run_frame("partial_timeout", stim_frame[0], stim_resp[0]);
      end_test("partial_timeout");

      // Host holds off the reply
      start_test();
      last           = stim_frame.size() - 1;
      target         = xfer_count + 1;
      blocked_starts = 0;
      slave_resp     = stim_resp[last];
      reply_q.delete();
      @(posedge clk);
      #1 tx_block = 1'b1;
      send_frame(stim_frame[last]);
      wait_xfer("flow_control", target);
      check_frame("flow_control", stim_frame[last], captured);
      repeat (FRAME_BYTES * BYTE_CYCLES) @(posedge clk);
      check_count("flow_control bytes while blocked", 0, reply_q.size());
      @(posedge clk);
      #1 tx_block = 1'b0;
      wait_replies("flow_control", FRAME_BYTES);
      check_readback("flow_control", stim_resp[last]);
      check_count("flow_control start bits while blocked", 0, blocked_starts);
      end_test("flow_control");

      // Random idle gaps between frames
      for (int i = 0; i < stim_frame.size(); i++) begin
        repeat ($urandom_range(0, 31)) @(posedge clk);
        start_test();
        run_frame($sformatf("back_to_back_%0d", i), stim_frame[i], stim_resp[i]);
        end_test($sformatf("back_to_back_%0d", i));
      end
    end

    $display("Tests passed: %0d, failed: %0d, errors: %0d", tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
hw/mems_pkg.sv
hw/spi_xfer_if.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/cmd_parser.sv
hw/mems_spi_master.sv
hw/frame_clk_gen.sv
hw/mems_bridge_top.sv
sim/mems_bridge_sva.sv
sim/mems_bridge_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the MEMS bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module mems_bridge_tb -f project.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vmems_bridge_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# Verdict comes from the log
if grep -q "^Finished with no errors$" "$LOG"; then
  echo "Simulation passed"
  exit 0
fi
echo "Simulation failed"
exit 1

// File: sim/mems_stim.txt
800F00 5A5AA5
0F1234 00FF00
A5C3E1 123456
7FFFFF FFFFFF
000000 000000
FFFFFF 800001
3C0001 ABCDEF
C00080 7E817E
124800 0F0F0F
E6D5C4 C0FFEE
